//--- Makefile
VERILATOR  ?= verilator
TOP        := emu_tb
RTL_TOP    := emu_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/1ps
BIN        := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

# build and run, the exit status of the simulation is the result
all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(BIN)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
+incdir+hdl
hdl/emu_time_pkg.sv
hdl/emu_osc_pkg.sv
hdl/osc_model.sv
hdl/dt_min_reduce.sv
hdl/emu_time_mgr.sv
hdl/emu_top.sv
tests/tb_clk_gen.sv
tests/emu_tb.sv

//--- hdl/dt_min_reduce.sv
`include "emu_macros.svh"

module dt_min_reduce (
    input  emu_time_pkg::dt_t [`N_OSC-1:0] req,
    input  emu_time_pkg::ext_req_t         ext_req,
    output emu_time_pkg::dt_t              dt_min
);
    import emu_time_pkg::*;

    // oscillators plus one slot for the external request
    localparam int N_IN = `N_OSC + 1;
    // leaf count rounded up to a power of two
    localparam int N_LEAF = 1 << $clog2(N_IN);
    // heap layout, node k has children 2k+1 and 2k+2
    localparam int N_NODE = 2 * N_LEAF - 1;

    dt_t node [N_NODE];

    // leaves sit at the end of the heap
    for (genvar l = 0; l < N_LEAF; l++) begin : g_leaf
        if (l < `N_OSC) begin : g_osc
            assign node[N_LEAF-1+l] = req[l];
        end else if (l == `N_OSC) begin : g_ext
            // invalid external request must not limit the step
            assign node[N_LEAF-1+l] = ext_req.valid ? ext_req.dt : DT_MAX;
        end else begin : g_pad
            // unused leaves never win
            assign node[N_LEAF-1+l] = DT_MAX;
        end
    end

    // pairwise minimum, one level of the tree per halving
    for (genvar n = 0; n < N_LEAF - 1; n++) begin : g_node
        assign node[n] = dt_min2(node[2*n+1], node[2*n+2]);
    end

    // root is the smallest pending event
    // stepping by it never jumps over any edge or external request
    assign dt_min = node[0];

endmodule

//--- hdl/emu_macros.svh
`ifndef EMU_MACROS_SVH
`define EMU_MACROS_SVH

// timestep width in ticks
// all steps are unsigned tick counts
`define DT_WIDTH 16

// emulated time counter width
// wide enough to run for a long time without wrapping
`define TIME_WIDTH 40

// number of emulated oscillators in the top level
`define N_OSC 2

// half-periods loaded at reset, in ticks
// runtime config loads can override these per oscillator
`define DEF_T_HI 6
`define DEF_T_LO 9

`endif

//--- hdl/emu_osc_pkg.sv
`include "emu_macros.svh"

package emu_osc_pkg;

    // half-period pair for one oscillator
    // t_hi is the time spent high, t_lo the time spent low
    typedef struct packed {
        emu_time_pkg::dt_t t_hi;
        emu_time_pkg::dt_t t_lo;
    } osc_cfg_t;

    // what each oscillator reports to the rest of the design
    // clk_val is the emulated clock level
    // dt_req is the emulated time left until the next edge
    typedef struct packed {
        logic              clk_val;
        emu_time_pkg::dt_t dt_req;
    } osc_status_t;

    // config held after reset
    localparam osc_cfg_t OSC_CFG_DEFAULT = '{
        t_hi: emu_time_pkg::dt_t'(`DEF_T_HI),
        t_lo: emu_time_pkg::dt_t'(`DEF_T_LO)
    };

endpackage

//--- hdl/emu_time_mgr.sv
module emu_time_mgr (
    input  logic                    __emu_clk,
    input  logic                    __emu_rst,
    input  logic                    pause,
    input  emu_time_pkg::dt_t       dt_min,
    output emu_time_pkg::dt_t       emu_dt,
    output emu_time_pkg::emu_time_t emu_time
);
    import emu_time_pkg::*;

    // step issued this cycle
    dt_t       dt_gated;
    // accumulated emulated time
    emu_time_t time_q;
    // step widened to the time counter
    emu_time_t dt_ext;
    emu_time_t time_nxt;

    // pause freezes emulation by issuing a zero step
    // every oscillator then holds its request and level
    assign dt_gated = pause ? '0 : dt_min;

    // dt_min comes straight from registered requests
    // so each clock cycle is one full emulated step
    assign emu_dt = dt_gated;

    assign dt_ext   = emu_time_t'(dt_gated);
    assign time_nxt = time_q + dt_ext;

    // time advances by the step issued in the same cycle
    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            time_q <= '0;
        end else begin
            time_q <= time_nxt;
        end
    end

    assign emu_time = time_q;

    // no emulated time passes while paused
    a_pause_zero_dt: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        pause |-> (emu_dt == '0)
    ) else $error("emu_time_mgr: emu_dt %0d while paused", emu_dt);

endmodule

//--- hdl/emu_time_pkg.sv
`include "emu_macros.svh"

package emu_time_pkg;

    // one emulated timestep in ticks
    typedef logic [`DT_WIDTH-1:0] dt_t;

    // accumulated emulated time in ticks
    typedef logic [`TIME_WIDTH-1:0] emu_time_t;

    // largest representable step
    // used as the neutral element of the minimum
    localparam dt_t DT_MAX = '1;

    // timestep request from outside the oscillator set
    // e.g. an analog block that wants finer steps for a while
    typedef struct packed {
        logic valid;
        dt_t  dt;
    } ext_req_t;

    // smaller of two requests, ties go to the first
    function automatic dt_t dt_min2(input dt_t a, input dt_t b);
        return (a <= b) ? a : b;
    endfunction

endpackage

//--- hdl/emu_top.sv
`include "emu_macros.svh"

module emu_top (
    input  logic                          __emu_clk,
    input  logic                          __emu_rst,
    input  logic                          pause,
    input  emu_time_pkg::ext_req_t        ext_req,
    input  logic                          cfg_load,
    input  logic [$clog2(`N_OSC)-1:0]     cfg_sel,
    input  emu_osc_pkg::osc_cfg_t         cfg,
    output logic [`N_OSC-1:0]             osc_clk,
    output emu_time_pkg::dt_t             emu_dt,
    output emu_time_pkg::emu_time_t       emu_time
);
    import emu_time_pkg::*;
    import emu_osc_pkg::*;

    localparam int SEL_W = $clog2(`N_OSC);

    // per-oscillator state as seen by the reducer
    osc_status_t [`N_OSC-1:0] osc_stat;
    dt_t         [`N_OSC-1:0] osc_req;
    // one-hot config load strobes
    logic        [`N_OSC-1:0] osc_load;
    // smallest pending event before pause gating
    dt_t                      dt_min;

    for (genvar i = 0; i < `N_OSC; i++) begin : g_osc
        // route the shared load strobe to the selected oscillator only
        assign osc_load[i] = cfg_load && (cfg_sel == SEL_W'(i));

        osc_model u_osc (
            .__emu_clk (__emu_clk),
            .__emu_rst (__emu_rst),
            .emu_dt    (emu_dt),
            .cfg_load  (osc_load[i]),
            .cfg       (cfg),
            .status    (osc_stat[i])
        );

        assign osc_clk[i] = osc_stat[i].clk_val;
        assign osc_req[i] = osc_stat[i].dt_req;
    end

    dt_min_reduce u_reduce (
        .req     (osc_req),
        .ext_req (ext_req),
        .dt_min  (dt_min)
    );

    emu_time_mgr u_time_mgr (
        .__emu_clk (__emu_clk),
        .__emu_rst (__emu_rst),
        .pause     (pause),
        .dt_min    (dt_min),
        .emu_dt    (emu_dt),
        .emu_time  (emu_time)
    );

endmodule

//--- hdl/osc_model.sv
`include "emu_macros.svh"

module osc_model (
    input  logic                    __emu_clk,
    input  logic                    __emu_rst,
    input  emu_time_pkg::dt_t       emu_dt,
    input  logic                    cfg_load,
    input  emu_osc_pkg::osc_cfg_t   cfg,
    output emu_osc_pkg::osc_status_t status
);
    import emu_time_pkg::*;
    import emu_osc_pkg::*;

    // emulated clock level
    logic     clk_val;
    // emulated time left until the next edge
    dt_t      dt_req;
    // half-periods applied at the next toggle
    osc_cfg_t shadow;
    // config seen by the toggle logic this cycle
    osc_cfg_t cfg_eff;

    logic dt_req_eq_emu_dt;
    dt_t  dt_req_minus_emu_dt;
    dt_t  next_half_period;
    dt_t  dt_req_nxt;

    // a load in the same cycle as a toggle already counts as the next toggle
    assign cfg_eff = cfg_load ? cfg : shadow;

    // edge is due when the global step lands exactly on our request
    assign dt_req_eq_emu_dt = (dt_req == emu_dt);

    // remaining time once this step has elapsed
    assign dt_req_minus_emu_dt = dt_req - emu_dt;

    // new level is ~clk_val
    // going high means a high phase, so t_hi
    assign next_half_period = clk_val ? cfg_eff.t_lo : cfg_eff.t_hi;

    // reload on toggle, else count down
    // zero step leaves dt_req as it is
    assign dt_req_nxt = dt_req_eq_emu_dt ? next_half_period : dt_req_minus_emu_dt;

    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            clk_val <= 1'b0;
            dt_req  <= dt_t'(`DEF_T_LO);
        end else begin
            if (dt_req_eq_emu_dt) begin
                clk_val <= ~clk_val;
            end
            dt_req <= dt_req_nxt;
        end
    end

    // shadow config, written by the top level strobe
    // half-period already in progress keeps its loaded dt_req
    always_ff @(posedge __emu_clk) begin
        if (__emu_rst) begin
            shadow <= OSC_CFG_DEFAULT;
        end else if (cfg_load) begin
            shadow <= cfg;
        end
    end

    assign status.clk_val = clk_val;
    assign status.dt_req  = dt_req;

    // zero request would pin the global step at zero forever
    a_req_nonzero: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        dt_req != '0
    ) else $error("osc_model: dt_req is zero");

    // reducer and time manager must never step past this edge
    a_no_overshoot: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        emu_dt <= dt_req
    ) else $error("osc_model: emu_dt %0d exceeds dt_req %0d", emu_dt, dt_req);

endmodule

//--- tests/emu_tb.sv
`include "emu_macros.svh"

module emu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import emu_time_pkg::*;
    import emu_osc_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 5;
    localparam int N_CYCLES   = 3000;
    // spare cycles for reset release and the final check
    localparam int MARGIN     = 100;
    localparam int SEED       = 59997;
    localparam int SEL_W      = $clog2(`N_OSC);

    logic                    __emu_clk;
    logic                    __emu_rst;
    logic                    pause;
    ext_req_t                ext_req;
    logic                    cfg_load;
    logic [SEL_W-1:0]        cfg_sel;
    osc_cfg_t                cfg;
    logic [`N_OSC-1:0]       osc_clk;
    dt_t                     emu_dt;
    emu_time_t               emu_time;

    // reference model state, one entry per oscillator
    logic [`N_OSC-1:0] m_clk;
    dt_t               m_req [`N_OSC];
    osc_cfg_t          m_shadow [`N_OSC];
    logic              m_cfg_seen [`N_OSC];
    emu_time_t         m_time;
    // start and length of the phase in progress
    emu_time_t         m_ph_start [`N_OSC];
    dt_t               m_ph_len [`N_OSC];
    // start and length of the phase that ended at the last toggle
    emu_time_t         m_prev_start [`N_OSC];
    dt_t               m_prev_len [`N_OSC];

    // expected step and helpers, combinational from the model
    dt_t  osc_min;
    dt_t  step_min;
    dt_t  exp_dt;
    logic ext_wins;

    // how often the stimulus reached each kind of check
    int pause_cycles;
    int ext_win_cycles;
    int toggle_count;
    int cfg_load_count;
    int loaded_phases;

    tb_clk_gen #(
        .PERIOD     (CLK_PERIOD),
        .RST_CYCLES (RST_CYCLES)
    ) u_clk_gen (
        .__emu_clk (__emu_clk),
        .__emu_rst (__emu_rst)
    );

    emu_top dut0 (
        .__emu_clk (__emu_clk),
        .__emu_rst (__emu_rst),
        .pause     (pause),
        .ext_req   (ext_req),
        .cfg_load  (cfg_load),
        .cfg_sel   (cfg_sel),
        .cfg       (cfg),
        .osc_clk   (osc_clk),
        .emu_dt    (emu_dt),
        .emu_time  (emu_time)
    );

    task automatic stop_on_mismatch(input string what);
        $display("FAILED at %0d ns: %s", $time, what);
        $display("TB FAILED");
        $fatal(1, "check failed, run stopped");
    endtask

    // smallest pending event seen by the model
    always_comb begin
        osc_min = '1;
        for (int i = 0; i < `N_OSC; i++) begin
            if (m_req[i] < osc_min) begin
                osc_min = m_req[i];
            end
        end
        step_min = osc_min;
        // an invalid external request never limits the step
        if (ext_req.valid && (ext_req.dt < step_min)) begin
            step_min = ext_req.dt;
        end
        exp_dt   = pause ? '0 : step_min;
        ext_wins = !pause && ext_req.valid && (ext_req.dt < osc_min);
    end

    // reference model, advanced on the same edge as the DUT
    always @(posedge __emu_clk) begin : ref_model
        logic     load_i;
        osc_cfg_t use_cfg;
        dt_t      half;
        if (__emu_rst) begin
            m_time <= '0;
            for (int i = 0; i < `N_OSC; i++) begin
                m_clk[i]        <= 1'b0;
                m_req[i]        <= dt_t'(`DEF_T_LO);
                m_shadow[i]     <= '{t_hi: dt_t'(`DEF_T_HI), t_lo: dt_t'(`DEF_T_LO)};
                m_cfg_seen[i]   <= 1'b0;
                m_ph_start[i]   <= '0;
                m_ph_len[i]     <= dt_t'(`DEF_T_LO);
                m_prev_start[i] <= '0;
                m_prev_len[i]   <= '0;
            end
        end else begin
            m_time <= m_time + emu_time_t'(exp_dt);
            for (int i = 0; i < `N_OSC; i++) begin
                load_i  = cfg_load && (cfg_sel == SEL_W'(i));
                // a load on the toggle edge already shapes the next phase
                use_cfg = load_i ? cfg : m_shadow[i];
                if (m_req[i] == exp_dt) begin
                    // new level is the inverse, high phase uses t_hi
                    half = m_clk[i] ? use_cfg.t_lo : use_cfg.t_hi;
                    m_clk[i]        <= ~m_clk[i];
                    m_req[i]        <= half;
                    m_prev_start[i] <= m_ph_start[i];
                    m_prev_len[i]   <= m_ph_len[i];
                    m_ph_start[i]   <= m_time + emu_time_t'(exp_dt);
                    m_ph_len[i]     <= half;
                    toggle_count = toggle_count + 1;
                    if (m_cfg_seen[i] || load_i) begin
                        loaded_phases = loaded_phases + 1;
                    end
                end else begin
                    m_req[i] <= m_req[i] - exp_dt;
                end
                if (load_i) begin
                    m_shadow[i]   <= cfg;
                    m_cfg_seen[i] <= 1'b1;
                end
            end
            if (pause) begin
                pause_cycles = pause_cycles + 1;
            end
            if (ext_wins) begin
                ext_win_cycles = ext_win_cycles + 1;
            end
            if (cfg_load) begin
                cfg_load_count = cfg_load_count + 1;
            end
        end
    end

    // first cycle out of reset
    a_reset_state: assert property (
        @(posedge __emu_clk)
        (!__emu_rst && $past(__emu_rst)) |->
            (osc_clk == '0 && emu_time == '0 && emu_dt == dt_t'(`DEF_T_LO))
    ) else stop_on_mismatch("state after reset is wrong");

    a_step_is_min: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        emu_dt == exp_dt
    ) else stop_on_mismatch($sformatf("emu_dt %0d, expected %0d", emu_dt, exp_dt));

    a_time_model: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        emu_time == m_time
    ) else stop_on_mismatch($sformatf("emu_time %0d, expected %0d", emu_time, m_time));

    // time grows by the expected step of the previous cycle
    a_time_step: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        !$past(__emu_rst) |-> (emu_time == $past(m_time) + emu_time_t'($past(exp_dt)))
    ) else stop_on_mismatch("emu_time did not grow by the last expected step");

    a_osc_level: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        osc_clk == m_clk
    ) else stop_on_mismatch($sformatf("osc_clk %b, expected %b", osc_clk, m_clk));

    a_pause_zero: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        pause |-> (emu_dt == '0)
    ) else stop_on_mismatch($sformatf("emu_dt %0d while paused", emu_dt));

    // paused cycle leaves everything frozen
    a_pause_hold: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        (!$past(__emu_rst) && $past(pause)) |->
            (emu_time == $past(emu_time) && osc_clk == $past(osc_clk))
    ) else stop_on_mismatch("state changed during a paused cycle");

    a_ext_step: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        ext_wins |-> (emu_dt == ext_req.dt)
    ) else stop_on_mismatch($sformatf("emu_dt %0d, external request %0d", emu_dt, ext_req.dt));

    // a step cut short by the external request fires no edge
    a_ext_no_toggle: assert property (
        @(posedge __emu_clk) disable iff (__emu_rst)
        (!$past(__emu_rst) && $past(ext_wins)) |-> (osc_clk == $past(osc_clk))
    ) else stop_on_mismatch("oscillator toggled on an external step");

    for (genvar g = 0; g < `N_OSC; g++) begin : g_osc_chk
        // edge happens exactly when the request runs out
        a_toggle_due: assert property (
            @(posedge __emu_clk) disable iff (__emu_rst)
            !$past(__emu_rst) |->
                ((osc_clk[g] != $past(osc_clk[g])) == ($past(m_req[g]) == $past(emu_dt)))
        ) else stop_on_mismatch($sformatf("osc %0d edge not in its due cycle", g));

        // phase that just ended lasted its half-period in emulated time
        a_phase_len: assert property (
            @(posedge __emu_clk) disable iff (__emu_rst)
            (!$past(__emu_rst) && osc_clk[g] != $past(osc_clk[g])) |->
                (emu_time - m_prev_start[g] == emu_time_t'(m_prev_len[g]))
        ) else stop_on_mismatch($sformatf("osc %0d phase lasted %0d, expected %0d",
            g, emu_time - m_prev_start[g], m_prev_len[g]));
    end

    // watchdog, sized from the test length
    initial begin
        repeat (RST_CYCLES + N_CYCLES + MARGIN) #(CLK_PERIOD);
        $display("watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    // random stimulus on falling edges
    initial begin
        pause_cycles   = 0;
        ext_win_cycles = 0;
        toggle_count   = 0;
        cfg_load_count = 0;
        loaded_phases  = 0;
        pause    = 1'b0;
        ext_req  = '0;
        cfg_load = 1'b0;
        cfg_sel  = '0;
        cfg      = '0;
        void'($urandom(SEED));

        @(negedge __emu_clk);
        while (__emu_rst) begin
            @(negedge __emu_clk);
        end
        // first active cycle keeps quiet inputs so the default step shows
        @(negedge __emu_clk);

        for (int c = 0; c < N_CYCLES; c++) begin
            pause         = ($urandom % 6) == 0;
            ext_req.valid = ($urandom % 4) == 0;
            ext_req.dt    = dt_t'(1 + ($urandom % 15));
            cfg_load      = ($urandom % 10) == 0;
            cfg_sel       = SEL_W'($urandom % `N_OSC);
            cfg.t_hi      = dt_t'(1 + ($urandom % 15));
            cfg.t_lo      = dt_t'(1 + ($urandom % 15));
            @(negedge __emu_clk);
        end

        pause    = 1'b0;
        ext_req  = '0;
        cfg_load = 1'b0;
        // let the last edge be checked
        @(negedge __emu_clk);

        if (pause_cycles > 0 && ext_win_cycles > 0 && toggle_count > 0 &&
            cfg_load_count > 0 && loaded_phases > 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("stimulus missed a check: pause %0d ext %0d toggles %0d loads %0d phases %0d",
                pause_cycles, ext_win_cycles, toggle_count, cfg_load_count, loaded_phases);
            $display("TB FAILED");
            $fatal(1, "incomplete stimulus");
        end
    end

endmodule

//--- tests/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 5
) (
    output logic __emu_clk,
    output logic __emu_rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // free running emulator clock
    initial begin
        __emu_clk = 1'b0;
        forever begin
            #(PERIOD / 2) __emu_clk = ~__emu_clk;
        end
    end

    // reset held for a fixed number of rising edges
    // released on a falling edge like every other input
    initial begin
        __emu_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge __emu_clk);
        @(negedge __emu_clk);
        __emu_rst = 1'b0;
    end

endmodule
